//--- source/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// datapath width, addresses and instruction words
`define XLEN 32

// global history length
`define GHIST_W 16

// direction tables
`define BIMODAL_ENTRIES 512  // indexed by pc[9:1]
`define TAGE_ENTRIES 256     // per tagged table
`define TAG_W 10
`define PARTIAL_TAG_BITS 6   // upper tag bits compared at lookup

// target buffer, direct mapped on pc[9:2]
`define BTB_ENTRIES 256
`define BTB_TAG_W 22

`endif

//--- source/bp_pkg.sv
package bp_pkg;

    // table that supplied the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_t;

    typedef logic [1:0] ctr2_t;  // msb set means taken

    localparam ctr2_t CTR_STRONG_NT = 2'b00;
    localparam ctr2_t CTR_WEAK_NT   = 2'b01;
    localparam ctr2_t CTR_WEAK_T    = 2'b10;
    localparam ctr2_t CTR_STRONG_T  = 2'b11;

    // saturating step toward the outcome
    function automatic ctr2_t ctr_update(ctr2_t ctr, logic taken);
        ctr2_t next;
        if (taken) begin
            next = (ctr == CTR_STRONG_T) ? ctr : ctr + 2'd1;
        end else begin
            next = (ctr == CTR_STRONG_NT) ? ctr : ctr - 2'd1;
        end
        return next;
    endfunction

endpackage

//--- source/rv_inst_pkg.sv
package rv_inst_pkg;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // B-type layout, offset bits scattered around rs1/rs2
    typedef struct packed {
        logic       imm_12;    // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fields_t;

    // J-type layout, 20-bit offset in jumbled order
    typedef struct packed {
        logic       imm_20;    // sign bit
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    // one fetched word, read as branch or as jump
    typedef union packed {
        b_fields_t b_view;
        j_fields_t j_view;
    } rv_inst_t;

endpackage

//--- source/direction_predictor.sv
`include "bp_defs.svh"

module direction_predictor (
    input  logic                clk,
    input  logic                rst,
    input  logic [`XLEN-1:0]    req_pc_i,
    output logic                dir_taken_o,
    output bp_pkg::provider_t   dir_provider_o,
    output logic [`GHIST_W-1:0] history_o,
    input  logic                upd_valid_i,
    input  logic [`XLEN-1:0]    upd_pc_i,
    input  logic [`GHIST_W-1:0] upd_history_i,
    input  bp_pkg::provider_t   upd_provider_i,
    input  logic                upd_taken_i,
    input  logic                upd_correct_i
);
    localparam int BM_IDX_W = $clog2(`BIMODAL_ENTRIES);
    localparam int TIDX_W   = $clog2(`TAGE_ENTRIES);

    logic [`GHIST_W-1:0] ghist;  // newest outcome in bit 0

    bp_pkg::ctr2_t     bm_ctr   [`BIMODAL_ENTRIES];
    logic              t0_valid [`TAGE_ENTRIES];
    logic [`TAG_W-1:0] t0_tag   [`TAGE_ENTRIES];
    bp_pkg::ctr2_t     t0_ctr   [`TAGE_ENTRIES];
    logic              t1_valid [`TAGE_ENTRIES];
    logic [`TAG_W-1:0] t1_tag   [`TAGE_ENTRIES];
    bp_pkg::ctr2_t     t1_ctr   [`TAGE_ENTRIES];

    // index and tag hashes, shared by lookup and update
    function automatic logic [TIDX_W-1:0] t0_index(logic [`XLEN-1:0] pc,
                                                    logic [`GHIST_W-1:0] hist);
        return pc[TIDX_W-1:0] ^ hist[TIDX_W-1:0];
    endfunction

    function automatic logic [TIDX_W-1:0] t1_index(logic [`XLEN-1:0] pc,
                                                    logic [`GHIST_W-1:0] hist);
        return pc[TIDX_W-1:0] ^ hist[`GHIST_W-1 -: TIDX_W];
    endfunction

    function automatic logic [`TAG_W-1:0] t0_tag_of(logic [`XLEN-1:0] pc,
                                                     logic [`GHIST_W-1:0] hist);
        return pc[`TAG_W+TIDX_W-1:TIDX_W] ^ hist[`GHIST_W-1 -: `TAG_W];
    endfunction

    function automatic logic [`TAG_W-1:0] t1_tag_of(logic [`XLEN-1:0] pc,
                                                     logic [`GHIST_W-1:0] hist);
        return pc[`TAG_W+TIDX_W-1:TIDX_W] ^ {{(`TAG_W-TIDX_W){1'b0}}, hist[TIDX_W-1:0]};
    endfunction

    logic [BM_IDX_W-1:0] lk_bm_idx;
    logic [TIDX_W-1:0]   lk_t0_idx;
    logic [TIDX_W-1:0]   lk_t1_idx;
    logic [`TAG_W-1:0]   lk_t0_tag;
    logic [`TAG_W-1:0]   lk_t1_tag;
    logic                t0_hit;
    logic                t1_hit;

    assign lk_bm_idx = req_pc_i[BM_IDX_W:1];
    assign lk_t0_idx = t0_index(req_pc_i, ghist);
    assign lk_t1_idx = t1_index(req_pc_i, ghist);
    assign lk_t0_tag = t0_tag_of(req_pc_i, ghist);
    assign lk_t1_tag = t1_tag_of(req_pc_i, ghist);

    // only the upper tag bits take part in the match
    assign t0_hit = t0_valid[lk_t0_idx] &&
        (t0_tag[lk_t0_idx][`TAG_W-1 -: `PARTIAL_TAG_BITS] ==
         lk_t0_tag[`TAG_W-1 -: `PARTIAL_TAG_BITS]);
    assign t1_hit = t1_valid[lk_t1_idx] &&
        (t1_tag[lk_t1_idx][`TAG_W-1 -: `PARTIAL_TAG_BITS] ==
         lk_t1_tag[`TAG_W-1 -: `PARTIAL_TAG_BITS]);

    always_comb begin
        if (t1_hit) begin  // longest history wins
            dir_provider_o = bp_pkg::PROV_T1;
            dir_taken_o    = t1_ctr[lk_t1_idx][1];
        end else if (t0_hit) begin
            dir_provider_o = bp_pkg::PROV_T0;
            dir_taken_o    = t0_ctr[lk_t0_idx][1];
        end else begin
            dir_provider_o = bp_pkg::PROV_BIMODAL;
            dir_taken_o    = bm_ctr[lk_bm_idx][1];
        end
    end

    assign history_o = ghist;

    // update side, hashed with the history the prediction saw
    logic [BM_IDX_W-1:0] u_bm_idx;
    logic [TIDX_W-1:0]   u_t0_idx;
    logic [TIDX_W-1:0]   u_t1_idx;
    logic [`TAG_W-1:0]   u_t0_tag;
    logic [`TAG_W-1:0]   u_t1_tag;
    logic                bm_miss;
    logic                alloc_t1;
    logic                alloc_t0;
    bp_pkg::ctr2_t       alloc_ctr;
    bp_pkg::ctr2_t       strong_ctr;

    assign u_bm_idx = upd_pc_i[BM_IDX_W:1];
    assign u_t0_idx = t0_index(upd_pc_i, upd_history_i);
    assign u_t1_idx = t1_index(upd_pc_i, upd_history_i);
    assign u_t0_tag = t0_tag_of(upd_pc_i, upd_history_i);
    assign u_t1_tag = t1_tag_of(upd_pc_i, upd_history_i);

    assign bm_miss  = upd_valid_i && !upd_correct_i &&
                      (upd_provider_i == bp_pkg::PROV_BIMODAL);
    assign alloc_t1 = bm_miss && (!t1_valid[u_t1_idx] || t1_tag[u_t1_idx] != u_t1_tag);
    assign alloc_t0 = bm_miss && !alloc_t1 &&
                      (!t0_valid[u_t0_idx] || t0_tag[u_t0_idx] != u_t0_tag);

    assign alloc_ctr  = upd_taken_i ? bp_pkg::CTR_WEAK_T : bp_pkg::CTR_WEAK_NT;
    assign strong_ctr = upd_taken_i ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_STRONG_NT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < `BIMODAL_ENTRIES; i++) begin
                bm_ctr[i] <= bp_pkg::CTR_WEAK_NT;
            end
            for (int i = 0; i < `TAGE_ENTRIES; i++) begin
                t0_valid[i] <= 1'b0;
                t0_ctr[i]   <= bp_pkg::CTR_WEAK_NT;
                t1_valid[i] <= 1'b0;
                t1_ctr[i]   <= bp_pkg::CTR_WEAK_NT;
            end
        end else if (upd_valid_i) begin
            ghist            <= {ghist[`GHIST_W-2:0], upd_taken_i};
            bm_ctr[u_bm_idx] <= bp_pkg::ctr_update(bm_ctr[u_bm_idx], upd_taken_i);

            if (alloc_t1) begin
                t1_valid[u_t1_idx] <= 1'b1;
                t1_ctr[u_t1_idx]   <= alloc_ctr;
            end else if (upd_provider_i == bp_pkg::PROV_T1) begin
                t1_ctr[u_t1_idx] <= upd_correct_i ?
                    bp_pkg::ctr_update(t1_ctr[u_t1_idx], upd_taken_i) : strong_ctr;
            end

            if (alloc_t0) begin
                t0_valid[u_t0_idx] <= 1'b1;
                t0_ctr[u_t0_idx]   <= alloc_ctr;
            end else if (upd_provider_i == bp_pkg::PROV_T0) begin
                t0_ctr[u_t0_idx] <= upd_correct_i ?
                    bp_pkg::ctr_update(t0_ctr[u_t0_idx], upd_taken_i) : strong_ctr;
            end
        end
    end

    // tags only change on allocation
    always_ff @(posedge clk) begin
        if (alloc_t1) begin
            t1_tag[u_t1_idx] <= u_t1_tag;
        end
        if (alloc_t0) begin
            t0_tag[u_t0_idx] <= u_t0_tag;
        end
    end

endmodule

//--- source/branch_target_buffer.sv
`include "bp_defs.svh"

module branch_target_buffer (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] req_pc_i,
    output logic             btb_hit_o,
    output logic [`XLEN-1:0] btb_target_o,
    input  logic             upd_valid_i,
    input  logic [`XLEN-1:0] upd_pc_i,
    input  logic             upd_taken_i,
    input  logic [`XLEN-1:0] upd_target_i
);
    localparam int IDX_W = $clog2(`BTB_ENTRIES);

    logic                 entry_valid  [`BTB_ENTRIES];
    logic [`BTB_TAG_W-1:0] entry_tag    [`BTB_ENTRIES];
    logic [`XLEN-1:0]     entry_target [`BTB_ENTRIES];

    logic [IDX_W-1:0]      lk_idx;
    logic [`BTB_TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0]      u_idx;
    logic [`BTB_TAG_W-1:0] u_tag;
    logic                  fill;

    // word aligned index, tag from the top pc bits
    assign lk_idx = req_pc_i[IDX_W+1:2];
    assign lk_tag = req_pc_i[`XLEN-1 -: `BTB_TAG_W];
    assign u_idx  = upd_pc_i[IDX_W+1:2];
    assign u_tag  = upd_pc_i[`XLEN-1 -: `BTB_TAG_W];

    assign btb_hit_o    = entry_valid[lk_idx] && (entry_tag[lk_idx] == lk_tag);
    assign btb_target_o = entry_target[lk_idx];

    assign fill = upd_valid_i && upd_taken_i;  // not-taken outcomes leave the entry alone

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (fill) begin
            entry_valid[u_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            entry_tag[u_idx]    <= u_tag;
            entry_target[u_idx] <= upd_target_i;
        end
    end

endmodule

//--- source/prediction_select.sv
`include "bp_defs.svh"

module prediction_select (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  logic [`XLEN-1:0]      req_pc_i,
    input  rv_inst_pkg::rv_inst_t req_inst_i,
    input  logic                  dir_taken_i,
    input  bp_pkg::provider_t     dir_provider_i,
    input  logic [`GHIST_W-1:0]   history_i,
    input  logic                  btb_hit_i,
    input  logic [`XLEN-1:0]      btb_target_i,
    output logic                  pred_valid_o,
    output logic                  pred_is_branch_o,
    output logic                  pred_taken_o,
    output logic [`XLEN-1:0]      pred_target_o,
    output bp_pkg::provider_t     pred_provider_o,
    output logic [`GHIST_W-1:0]   pred_history_o
);
    logic [6:0]       opcode;
    logic             is_cond;
    logic             is_jal;
    logic             is_jalr;
    logic             is_branch;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] fall_through;
    logic             taken_d;
    logic [`XLEN-1:0] target_d;

    // opcode sits in the same bits for both views
    assign opcode    = req_inst_i.b_view.opcode;
    assign is_cond   = (opcode == rv_inst_pkg::OPC_BRANCH);
    assign is_jal    = (opcode == rv_inst_pkg::OPC_JAL);
    assign is_jalr   = (opcode == rv_inst_pkg::OPC_JALR);
    assign is_branch = is_cond || is_jal || is_jalr;

    // sign extended offsets, bit 0 always zero
    assign b_imm = {{(`XLEN-12){req_inst_i.b_view.imm_12}},
                    req_inst_i.b_view.imm_11,
                    req_inst_i.b_view.imm_10_5,
                    req_inst_i.b_view.imm_4_1,
                    1'b0};
    assign j_imm = {{(`XLEN-20){req_inst_i.j_view.imm_20}},
                    req_inst_i.j_view.imm_19_12,
                    req_inst_i.j_view.imm_11,
                    req_inst_i.j_view.imm_10_1,
                    1'b0};

    assign fall_through = req_pc_i + `XLEN'd4;

    always_comb begin
        taken_d  = 1'b0;  // jalr and non-branches fall through
        target_d = fall_through;
        if (is_jal) begin
            taken_d  = 1'b1;
            target_d = btb_hit_i ? btb_target_i : req_pc_i + j_imm;
        end else if (is_cond && dir_taken_i) begin
            taken_d  = 1'b1;
            target_d = btb_hit_i ? btb_target_i : req_pc_i + b_imm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid_o     <= 1'b0;
            pred_is_branch_o <= 1'b0;
            pred_taken_o     <= 1'b0;
        end else begin
            pred_valid_o     <= req_valid_i;
            pred_is_branch_o <= req_valid_i && is_branch;
            pred_taken_o     <= req_valid_i && taken_d;  // low on idle cycles
        end
    end

    // payload held until the next request
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            pred_target_o   <= target_d;
            pred_provider_o <= dir_provider_i;
            pred_history_o  <= history_i;  // returned later with the resolution
        end
    end

endmodule

//--- source/branch_predictor.sv
`include "bp_defs.svh"

module branch_predictor (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  logic [`XLEN-1:0]      req_pc_i,
    input  rv_inst_pkg::rv_inst_t req_inst_i,
    output logic                  pred_valid_o,
    output logic                  pred_is_branch_o,
    output logic                  pred_taken_o,
    output logic [`XLEN-1:0]      pred_target_o,
    output bp_pkg::provider_t     pred_provider_o,
    output logic [`GHIST_W-1:0]   pred_history_o,
    input  logic                  upd_valid_i,
    input  logic [`XLEN-1:0]      upd_pc_i,
    input  logic [`GHIST_W-1:0]   upd_history_i,
    input  bp_pkg::provider_t     upd_provider_i,
    input  logic                  upd_taken_i,
    input  logic                  upd_correct_i,
    input  logic [`XLEN-1:0]      upd_target_i
);
    logic                dir_taken;
    bp_pkg::provider_t   dir_provider;
    logic [`GHIST_W-1:0] dir_history;
    logic                btb_hit;
    logic [`XLEN-1:0]    btb_target;

    // both lookups are combinational on the fetch pc
    direction_predictor direction_predictor_inst (
        .clk            (clk),
        .rst            (rst),
        .req_pc_i       (req_pc_i),
        .dir_taken_o    (dir_taken),
        .dir_provider_o (dir_provider),
        .history_o      (dir_history),
        .upd_valid_i    (upd_valid_i),
        .upd_pc_i       (upd_pc_i),
        .upd_history_i  (upd_history_i),
        .upd_provider_i (upd_provider_i),
        .upd_taken_i    (upd_taken_i),
        .upd_correct_i  (upd_correct_i)
    );

    branch_target_buffer branch_target_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .req_pc_i     (req_pc_i),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i),
        .upd_target_i (upd_target_i)
    );

    prediction_select prediction_select_inst (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .req_pc_i         (req_pc_i),
        .req_inst_i       (req_inst_i),
        .dir_taken_i      (dir_taken),
        .dir_provider_i   (dir_provider),
        .history_i        (dir_history),
        .btb_hit_i        (btb_hit),
        .btb_target_i     (btb_target),
        .pred_valid_o     (pred_valid_o),
        .pred_is_branch_o (pred_is_branch_o),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .pred_provider_o  (pred_provider_o),
        .pred_history_o   (pred_history_o)
    );

endmodule

//--- test/branch_predictor_chk.sv
`include "bp_defs.svh"

module branch_predictor_chk (
    input logic             clk,
    input logic             rst,
    input logic             req_valid_i,
    input logic [`XLEN-1:0] req_pc_i,
    input logic             pred_valid_o,
    input logic             pred_is_branch_o,
    input logic             pred_taken_o,
    input logic [`XLEN-1:0] pred_target_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // one cycle from request to prediction
    valid_follows_req: assert property (@(posedge clk) disable iff (rst)
        pred_valid_o == $past(req_valid_i))
        else $error("pred_valid_o does not follow req_valid_i by one cycle");

    taken_is_branch: assert property (@(posedge clk) disable iff (rst)
        pred_taken_o |-> pred_is_branch_o)
        else $error("taken prediction on a non-branch");

    // fall-through target
    not_taken_target: assert property (@(posedge clk) disable iff (rst)
        (pred_valid_o && !pred_taken_o) |-> (pred_target_o == $past(req_pc_i) + `XLEN'd4))
        else $error("not-taken target is not pc+4");

    idle_in_reset: assert property (@(posedge clk)
        rst |=> (!pred_valid_o && !pred_taken_o))
        else $error("prediction valid during reset");

endmodule

//--- test/branch_predictor_tb.sv
`include "bp_defs.svh"

module branch_predictor_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_LOOKUPS = 4000;
    localparam int STIM_CYCLES    = 4800;  // reset, directed part, random lookups at 7 of 8 cycles
    localparam int CYCLE_LIMIT    = 2 * STIM_CYCLES;

    typedef struct packed {
        logic [31:0]       pc;
        logic [31:0]       inst;
        logic              is_br;
        logic              taken;
        logic [31:0]       target;
        bp_pkg::provider_t prov;
        logic [15:0]       hist;
    } pred_rec_t;

    logic                  clk;
    logic                  rst;
    logic                  req_valid_i;
    logic [31:0]           req_pc_i;
    rv_inst_pkg::rv_inst_t req_inst_i;
    logic                  pred_valid_o;
    logic                  pred_is_branch_o;
    logic                  pred_taken_o;
    logic [31:0]           pred_target_o;
    bp_pkg::provider_t     pred_provider_o;
    logic [15:0]           pred_history_o;
    logic                  upd_valid_i;
    logic [31:0]           upd_pc_i;
    logic [15:0]           upd_history_i;
    bp_pkg::provider_t     upd_provider_i;
    logic                  upd_taken_i;
    logic                  upd_correct_i;
    logic [31:0]           upd_target_i;

    branch_predictor branch_predictor_inst (.*);

    bind branch_predictor branch_predictor_chk branch_predictor_chk_inst (
        .clk(clk), .rst(rst), .req_valid_i(req_valid_i), .req_pc_i(req_pc_i),
        .pred_valid_o(pred_valid_o), .pred_is_branch_o(pred_is_branch_o),
        .pred_taken_o(pred_taken_o), .pred_target_o(pred_target_o)
    );

    // reference model state
    logic [15:0] m_hist;
    logic [1:0]  m_bm      [512];
    logic        m_t0_v    [256];
    logic [9:0]  m_t0_tag  [256];
    logic [1:0]  m_t0_ctr  [256];
    logic        m_t1_v    [256];
    logic [9:0]  m_t1_tag  [256];
    logic [1:0]  m_t1_ctr  [256];
    logic        m_btb_v   [256];
    logic [21:0] m_btb_tag [256];
    logic [31:0] m_btb_tgt [256];

    pred_rec_t   exp_q[$];  // requests in flight
    pred_rec_t   obs_q[$];  // checked predictions awaiting resolution
    logic [31:0] rng;
    logic [31:0] pc_pool [8];
    int          cycle_count;

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic logic [1:0] sat_step(logic [1:0] c, logic t);
        if (t) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // RISC-V B and J immediates
    function automatic logic [31:0] b_offset(logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] j_offset(logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic pred_rec_t predict_ref(logic [31:0] pc, logic [31:0] inst);
        pred_rec_t  r;
        logic [7:0] i0;
        logic [7:0] i1;
        logic [9:0] g0;
        logic [9:0] g1;
        logic       dir;
        logic       hit;
        r.pc   = pc;
        r.inst = inst;
        r.hist = m_hist;
        i0 = pc[7:0] ^ m_hist[7:0];
        i1 = pc[7:0] ^ m_hist[15:8];
        g0 = pc[17:8] ^ m_hist[15:6];
        g1 = pc[17:8] ^ {2'b00, m_hist[7:0]};
        if (m_t1_v[i1] && m_t1_tag[i1][9:4] == g1[9:4]) begin
            r.prov = bp_pkg::PROV_T1;
            dir    = m_t1_ctr[i1][1];
        end else if (m_t0_v[i0] && m_t0_tag[i0][9:4] == g0[9:4]) begin
            r.prov = bp_pkg::PROV_T0;
            dir    = m_t0_ctr[i0][1];
        end else begin
            r.prov = bp_pkg::PROV_BIMODAL;
            dir    = m_bm[pc[9:1]][1];
        end
        hit = m_btb_v[pc[9:2]] && (m_btb_tag[pc[9:2]] == pc[31:10]);
        r.is_br = (inst[6:0] == rv_inst_pkg::OPC_BRANCH) || (inst[6:0] == rv_inst_pkg::OPC_JAL) ||
                  (inst[6:0] == rv_inst_pkg::OPC_JALR);
        r.taken  = 1'b0;
        r.target = pc + 32'd4;
        if (inst[6:0] == rv_inst_pkg::OPC_JAL) begin
            r.taken  = 1'b1;
            r.target = hit ? m_btb_tgt[pc[9:2]] : pc + j_offset(inst);
        end else if (inst[6:0] == rv_inst_pkg::OPC_BRANCH && dir) begin
            r.taken  = 1'b1;
            r.target = hit ? m_btb_tgt[pc[9:2]] : pc + b_offset(inst);
        end
        return r;
    endfunction

    function automatic void apply_update(logic [31:0] pc, logic [15:0] hist,
                                         bp_pkg::provider_t prov, logic taken,
                                         logic correct, logic [31:0] target);
        logic [7:0] i0;
        logic [7:0] i1;
        logic [9:0] g0;
        logic [9:0] g1;
        logic [1:0] fix;
        i0  = pc[7:0] ^ hist[7:0];
        i1  = pc[7:0] ^ hist[15:8];
        g0  = pc[17:8] ^ hist[15:6];
        g1  = pc[17:8] ^ {2'b00, hist[7:0]};
        fix = taken ? 2'b11 : 2'b00;
        m_hist = {m_hist[14:0], taken};
        m_bm[pc[9:1]] = sat_step(m_bm[pc[9:1]], taken);
        if (prov == bp_pkg::PROV_T1) begin
            m_t1_ctr[i1] = correct ? sat_step(m_t1_ctr[i1], taken) : fix;
        end else if (prov == bp_pkg::PROV_T0) begin
            m_t0_ctr[i0] = correct ? sat_step(m_t0_ctr[i0], taken) : fix;
        end else if (!correct) begin
            if (!m_t1_v[i1] || m_t1_tag[i1] != g1) begin
                m_t1_v[i1]   = 1'b1;
                m_t1_tag[i1] = g1;
                m_t1_ctr[i1] = taken ? 2'b10 : 2'b01;
            end else if (!m_t0_v[i0] || m_t0_tag[i0] != g0) begin
                m_t0_v[i0]   = 1'b1;
                m_t0_tag[i0] = g0;
                m_t0_ctr[i0] = taken ? 2'b10 : 2'b01;
            end
        end
        if (taken) begin
            m_btb_v[pc[9:2]]   = 1'b1;
            m_btb_tag[pc[9:2]] = pc[31:10];
            m_btb_tgt[pc[9:2]] = target;
        end
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // drives one clock of request and resolution and steps the model to match
    task automatic cycle_step(input logic rv, input logic [31:0] pc, input logic [31:0] inst,
                              input logic uv, input pred_rec_t u, input logic taken,
                              input logic [31:0] target);
        logic correct;
        @(posedge clk);
        correct = (u.taken == taken);
        req_valid_i    <= rv;
        req_pc_i       <= pc;
        req_inst_i     <= inst;
        upd_valid_i    <= uv;
        upd_pc_i       <= u.pc;
        upd_history_i  <= u.hist;
        upd_provider_i <= u.prov;
        upd_taken_i    <= taken;
        upd_correct_i  <= correct;
        upd_target_i   <= target;
        if (rv) begin
            exp_q.push_back(predict_ref(pc, inst));  // sees state before this update
        end
        if (uv) begin
            apply_update(u.pc, u.hist, u.prov, taken, correct, target);
        end
    endtask

    task automatic do_lookup(input logic [31:0] pc, input logic [31:0] inst,
                             output pred_rec_t r);
        cycle_step(1'b1, pc, inst, 1'b0, '0, 1'b0, 32'd0);
        while (obs_q.size() == 0) begin
            cycle_step(1'b0, 32'd0, 32'd0, 1'b0, '0, 1'b0, 32'd0);
        end
        r = obs_q.pop_front();
    endtask

    task automatic do_resolve(input pred_rec_t r, input logic taken, input logic [31:0] target);
        cycle_step(1'b0, 32'd0, 32'd0, 1'b1, r, taken, target);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    // compare each prediction with the model
    always @(negedge clk) begin
        pred_rec_t e;
        if (!rst && pred_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("a prediction came out with no request pending");
                $display("tests failed");
                $fatal(1, "unexpected prediction");
            end else begin
                e = exp_q.pop_front();
                check_eq(32'(pred_is_branch_o), 32'(e.is_br), "pred_is_branch_o");
                check_eq(32'(pred_taken_o), 32'(e.taken), "pred_taken_o");
                check_eq(pred_target_o, e.target, "pred_target_o");
                check_eq(32'(pred_provider_o), 32'(e.prov), "pred_provider_o");
                check_eq(32'(pred_history_o), 32'(e.hist), "pred_history_o");
                obs_q.push_back(e);
            end
        end
    end

    initial begin
        pred_rec_t   r;
        pred_rec_t   u;
        logic [15:0] h0;
        logic [31:0] r32;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] target;
        logic        rv;
        logic        uv;
        logic        taken;
        int          issued;
        logic [31:0] beq_40;
        logic [31:0] jal_100;

        beq_40  = {1'b0, 6'b000010, 5'd2, 5'd1, 3'b000, 4'b0000, 1'b0, 7'b1100011};
        jal_100 = {1'b0, 10'h080, 1'b0, 8'h00, 5'd1, 7'b1101111};
        pc_pool = '{32'h0000_0100, 32'h0000_0204, 32'h0000_0308, 32'h0001_0100,
                    32'h0000_0ffc, 32'h8000_0040, 32'h0002_4210, 32'h0000_0104};
        rng         = 32'hbbe4_119c;
        cycle_count = 0;
        issued      = 0;
        m_hist      = '0;
        for (int i = 0; i < 512; i++) begin
            m_bm[i] = 2'b01;
        end
        for (int i = 0; i < 256; i++) begin
            m_t0_v[i]  = 1'b0;
            m_t0_ctr[i] = 2'b01;
            m_t1_v[i]  = 1'b0;
            m_t1_ctr[i] = 2'b01;
            m_btb_v[i] = 1'b0;
        end
        rst            = 1'b1;
        req_valid_i    = 1'b0;
        req_pc_i       = '0;
        req_inst_i     = '0;
        upd_valid_i    = 1'b0;
        upd_pc_i       = '0;
        upd_history_i  = '0;
        upd_provider_i = bp_pkg::PROV_BIMODAL;
        upd_taken_i    = 1'b0;
        upd_correct_i  = 1'b0;
        upd_target_i   = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset state
        do_lookup(32'h0000_2000, beq_40, r);
        check_eq(32'(r.taken), 32'd0, "reset taken");
        check_eq(r.target, 32'h0000_2004, "reset target");
        check_eq(32'(r.prov), 32'(bp_pkg::PROV_BIMODAL), "reset provider");
        check_eq(32'(r.hist), 32'd0, "reset history");

        // jal target from immediate, then from the BTB
        do_lookup(32'h0000_3000, jal_100, r);
        check_eq(32'(r.taken), 32'd1, "jal taken");
        check_eq(r.target, 32'h0000_3100, "jal immediate target");
        do_resolve(r, 1'b1, 32'h0000_9000);
        do_lookup(32'h0000_3000, jal_100, r);
        check_eq(r.target, 32'h0000_9000, "jal btb target");

        // age the history so the training branch misses the tagged tables
        repeat (3) begin
            do_resolve(r, 1'b1, 32'h0000_9000);
        end

        // bimodal training
        repeat (2) begin
            do_lookup(32'h0000_2480, beq_40, r);
            do_resolve(r, 1'b1, 32'h0000_24c0);
        end
        do_lookup(32'h0000_2480, beq_40, r);
        check_eq(32'(r.prov), 32'(bp_pkg::PROV_BIMODAL), "trained provider");
        check_eq(32'(r.taken), 32'd1, "trained taken");
        check_eq(r.target, 32'h0000_24c0, "trained target");

        // history shift, then fill it with ones
        h0 = r.hist;
        do_resolve(r, 1'b1, 32'h0000_24c0);
        do_lookup(32'h0000_3800, jal_100, r);
        check_eq(32'(r.hist), 32'({h0[14:0], 1'b1}), "history shift");
        repeat (16) begin
            do_resolve(r, 1'b1, 32'h0000_3900);
            do_lookup(32'h0000_3800, jal_100, r);
        end
        check_eq(32'(r.hist), 32'h0000_ffff, "history all taken");

        // bimodal miss allocates a T1 entry that the same history then hits
        do_lookup(32'h0000_5a00, beq_40, r);
        check_eq(32'(r.prov), 32'(bp_pkg::PROV_BIMODAL), "pre-allocation provider");
        check_eq(32'(r.taken), 32'd0, "pre-allocation taken");
        do_resolve(r, 1'b1, 32'h0000_5a40);
        do_lookup(32'h0000_5a00, beq_40, r);
        check_eq(32'(r.prov), 32'(bp_pkg::PROV_T1), "allocated provider");
        check_eq(32'(r.taken), 32'd1, "allocated taken");

        // random stream with resolutions overlapping new lookups
        while (issued < RANDOM_LOOKUPS || exp_q.size() > 0 || obs_q.size() > 0) begin
            uv     = 1'b0;
            u      = '0;
            taken  = 1'b0;
            target = 32'd0;
            if (obs_q.size() > 0) begin
                u   = obs_q.pop_front();
                uv  = u.is_br;
                r32 = lcg_next();
                taken  = 1'b1;
                target = (r32[7:4] == 4'd0) ? {r32[31:10], 10'h0} : u.pc + j_offset(u.inst);
                if (u.inst[6:0] == rv_inst_pkg::OPC_BRANCH) begin
                    taken  = u.pc[2] ? (r32[1:0] != 2'd0) : r32[0];  // some pcs lean taken
                    target = (r32[7:4] == 4'd0) ? {r32[31:10], 10'h0} : u.pc + b_offset(u.inst);
                end else if (u.inst[6:0] == rv_inst_pkg::OPC_JALR) begin
                    target = {r32[31:2], 2'b00};
                end
            end
            r32  = lcg_next();
            rv   = (issued < RANDOM_LOOKUPS) && (r32[2:0] != 3'd0);
            pc   = pc_pool[r32[5:3]];
            inst = lcg_next();
            case (r32[8:6])
                3'd0, 3'd1, 3'd2, 3'd3: inst[6:0] = rv_inst_pkg::OPC_BRANCH;
                3'd4: inst[6:0] = rv_inst_pkg::OPC_JAL;
                3'd5: inst[6:0] = rv_inst_pkg::OPC_JALR;
                default: inst[6:0] = 7'b0010011;  // op-imm
            endcase
            if (rv) begin
                issued++;
            end
            cycle_step(rv, pc, inst, uv, u, taken, target);
        end
        cycle_step(1'b0, 32'd0, 32'd0, 1'b0, '0, 1'b0, 32'd0);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/bp_pkg.sv
source/rv_inst_pkg.sv
source/direction_predictor.sv
source/branch_target_buffer.sv
source/prediction_select.sv
source/branch_predictor.sv
test/branch_predictor_chk.sv
test/branch_predictor_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = branch_predictor_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) source/bp_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^all tests passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
